// ==== logic/pixel_pkg.sv ====
package pixel_pkg;

  localparam int PIXEL_W = 8;

  // Longest line the engine accepts, also the depth of each line buffer
  localparam int MAX_WIDTH = 256;

  // Column, row and width counters, wide enough to hold MAX_WIDTH itself
  localparam int COUNT_W = 9;

  localparam int WIN = 5;
  localparam int RING_N = 8;

  // Number of pixels in the window, the gain on a sample in the mean compare
  localparam int WIN_AREA = WIN * WIN;

  // WIN_AREA * 255 must fit, since the NI compare scales a sample by WIN_AREA
  localparam int SUM_W = 13;

  typedef logic [PIXEL_W-1:0] pixel_t;

  // Index 0 is east, then 45 degree steps counter-clockwise
  // 1 NE, 2 N, 3 NW, 4 W, 5 SW, 6 S, 7 SE
  typedef pixel_t [RING_N-1:0] ring_t;

  typedef logic [SUM_W-1:0] sum_t;

endpackage

// ==== logic/code_pkg.sv ====
package code_pkg;

  // One bit per ring direction, so this matches the ring size
  localparam int PATTERN_W = 8;

  // A riu2 code spans 0 to 9
  localparam int CODE_W = 4;

  // Bit k of a pattern belongs to direction k
  typedef logic [PATTERN_W-1:0] pattern_t;

  typedef logic [CODE_W-1:0] code_t;

  // Code for every pattern with more than two circular transitions
  localparam code_t NONUNIFORM_CODE = 4'd9;

endpackage

// ==== logic/ring_if.sv ====
`timescale 1ns/100ps

interface ring_if;
  import pixel_pkg::*;

  ring_t inner;     // Samples at distance 1 around the centre
  ring_t outer;     // Samples at distance 2, diagonals at the window corners
  sum_t patch_sum;  // Sum of all window pixels
  logic valid;      // Qualifies the three fields above

  modport src (
    output inner,
    output outer,
    output patch_sum,
    output valid
  );

  modport dst (
    input inner,
    input outer,
    input patch_sum,
    input valid
  );

endinterface

// ==== logic/window_gen.sv ====
`timescale 1ns/100ps

module window_gen (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [pixel_pkg::COUNT_W-1:0] img_width_i,
  input  logic                          sof_i,
  input  pixel_pkg::pixel_t             pixel_i,
  input  logic                          pixel_valid_i,
  ring_if.src                           ring
);
  import pixel_pkg::*;

  logic [COUNT_W-1:0] col_cnt;
  logic [COUNT_W-1:0] row_cnt;
  logic [COUNT_W-1:0] width_q;
  logic [COUNT_W-1:0] cur_col;
  logic [COUNT_W-1:0] cur_row;
  logic [COUNT_W-1:0] cur_width;
  logic [COUNT_W-2:0] lb_addr;
  logic               win_done;
  logic               s0_valid;
  logic               s1_valid;

  pixel_t col_in [WIN];
  pixel_t win [WIN][WIN];  // Row 0 is the oldest line, column WIN-1 the newest pixel
  sum_t   row_sum_c [WIN];
  sum_t   row_sum_q [WIN];
  sum_t   total_c;
  ring_t  s1_inner;
  ring_t  s1_outer;

  // The first pixel of a frame sits at position zero whatever the counters hold
  assign cur_col   = sof_i ? '0 : col_cnt;
  assign cur_row   = sof_i ? '0 : row_cnt;
  assign cur_width = sof_i ? img_width_i : width_q;
  assign lb_addr   = cur_col[COUNT_W-2:0];  // MAX_WIDTH is 2**(COUNT_W-1)

  // The newest pixel is the bottom-right corner of a window fully inside the image
  assign win_done = pixel_valid_i && (cur_col >= COUNT_W'(WIN - 1)) &&
                    (cur_row >= COUNT_W'(WIN - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
      width_q <= COUNT_W'(MAX_WIDTH);
    end else if (pixel_valid_i) begin
      if (sof_i) begin
        width_q <= img_width_i;
      end
      if (cur_col == cur_width - 1'b1) begin
        col_cnt <= '0;
        if (cur_row != '1) begin  // Saturates, only row >= 4 matters
          row_cnt <= cur_row + 1'b1;
        end
      end else begin
        col_cnt <= cur_col + 1'b1;
        row_cnt <= cur_row;
      end
    end
  end

  assign col_in[WIN-1] = pixel_i;

  // Buffer k holds line row-1-k and hands its old entry down to buffer k+1
  for (genvar k = 0; k < WIN - 1; k++) begin : g_line_buf
    pixel_t mem [MAX_WIDTH];

    assign col_in[WIN-2-k] = mem[lb_addr];

    always_ff @(posedge clk) begin
      if (pixel_valid_i) begin
        mem[lb_addr] <= col_in[WIN-1-k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int r = 0; r < WIN; r++) begin
        for (int c = 0; c < WIN - 1; c++) begin
          win[r][c] <= win[r][c+1];
        end
        win[r][WIN-1] <= col_in[r];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      row_sum_c[r] = '0;
      for (int c = 0; c < WIN; c++) begin
        row_sum_c[r] = row_sum_c[r] + sum_t'(win[r][c]);
      end
    end
  end

  always_comb begin
    total_c = '0;
    for (int r = 0; r < WIN; r++) begin
      total_c = total_c + row_sum_q[r];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s0_valid   <= 1'b0;
      s1_valid   <= 1'b0;
      ring.valid <= 1'b0;
    end else begin
      s0_valid   <= win_done;
      s1_valid   <= s0_valid;
      ring.valid <= s1_valid;
    end
  end

  // First stage samples the rings and the row sums of the settled window
  always_ff @(posedge clk) begin
    if (s0_valid) begin
      s1_inner[0] <= win[2][3];
      s1_outer[0] <= win[2][4];
      s1_inner[1] <= win[1][3];
      s1_outer[1] <= win[0][4];
      s1_inner[2] <= win[1][2];
      s1_outer[2] <= win[0][2];
      s1_inner[3] <= win[1][1];
      s1_outer[3] <= win[0][0];
      s1_inner[4] <= win[2][1];
      s1_outer[4] <= win[2][0];
      s1_inner[5] <= win[3][1];
      s1_outer[5] <= win[4][0];
      s1_inner[6] <= win[3][2];
      s1_outer[6] <= win[4][2];
      s1_inner[7] <= win[3][3];
      s1_outer[7] <= win[4][4];
      row_sum_q   <= row_sum_c;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      ring.inner     <= s1_inner;
      ring.outer     <= s1_outer;
      ring.patch_sum <= total_c;
    end
  end

  // A pixel at an edge column never completes a window
  a_no_edge_window: assert property (@(posedge clk) disable iff (!rst_n)
    (pixel_valid_i && cur_col < COUNT_W'(WIN - 1)) |=> ##2 !ring.valid);

  a_width_min: assert property (@(posedge clk) disable iff (!rst_n)
    width_q >= COUNT_W'(WIN));

endmodule

// ==== logic/ring_compare.sv ====
`timescale 1ns/100ps

module ring_compare (
  input  logic               clk,
  input  logic               rst_n,
  ring_if.dst                ring,
  output code_pkg::pattern_t ni_pattern_o,
  output code_pkg::pattern_t rd_pattern_o,
  output logic               pattern_valid_o
);
  import pixel_pkg::*;
  import code_pkg::*;

  pattern_t ni_bits;
  pattern_t rd_bits;

  // Comparing WIN_AREA * sample with the sum is the same as sample >= mean
  always_comb begin
    for (int k = 0; k < RING_N; k++) begin
      ni_bits[k] = (sum_t'(WIN_AREA) * sum_t'(ring.outer[k])) >= ring.patch_sum;
      rd_bits[k] = ring.outer[k] >= ring.inner[k];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pattern_valid_o <= 1'b0;
    end else begin
      pattern_valid_o <= ring.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ring.valid) begin
      ni_pattern_o <= ni_bits;
      rd_pattern_o <= rd_bits;
    end
  end

endmodule

// ==== logic/riu2_encode.sv ====
`timescale 1ns/100ps

module riu2_encode (
  input  logic               clk,
  input  logic               rst_n,
  input  code_pkg::pattern_t ni_pattern_i,
  input  code_pkg::pattern_t rd_pattern_i,
  input  logic               pattern_valid_i,
  output code_pkg::code_t    ni_code_o,
  output code_pkg::code_t    rd_code_o,
  output logic               code_valid_o
);
  import code_pkg::*;

  // Uniform patterns map to their count of ones, all others share one code
  function automatic code_t riu2(input pattern_t p);
    pattern_t edges;
    int       n_trans;
    edges   = p ^ {p[0], p[PATTERN_W-1:1]};  // Bit k marks a change between k and k+1
    n_trans = $countones(edges);
    if (n_trans <= 2) begin
      return code_t'($countones(p));
    end
    return NONUNIFORM_CODE;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_valid_o <= 1'b0;
    end else begin
      code_valid_o <= pattern_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pattern_valid_i) begin
      ni_code_o <= riu2(ni_pattern_i);
      rd_code_o <= riu2(rd_pattern_i);
    end
  end

  a_code_range: assert property (@(posedge clk) disable iff (!rst_n)
    code_valid_o |-> (ni_code_o <= NONUNIFORM_CODE) && (rd_code_o <= NONUNIFORM_CODE));

endmodule

// ==== logic/nird_top.sv ====
`timescale 1ns/100ps

module nird_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [pixel_pkg::COUNT_W-1:0] img_width_i,
  input  logic                          sof_i,
  input  pixel_pkg::pixel_t             pixel_i,
  input  logic                          pixel_valid_i,
  output code_pkg::code_t               ni_o,
  output code_pkg::code_t               rd_o,
  output logic                          data_valid_o
);
  import code_pkg::*;

  pattern_t ni_pattern;
  pattern_t rd_pattern;
  logic     pattern_valid;

  ring_if ring ();

  window_gen u_window_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .img_width_i   (img_width_i),
    .sof_i         (sof_i),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .ring          (ring.src)
  );

  ring_compare u_ring_compare (
    .clk             (clk),
    .rst_n           (rst_n),
    .ring            (ring.dst),
    .ni_pattern_o    (ni_pattern),
    .rd_pattern_o    (rd_pattern),
    .pattern_valid_o (pattern_valid)
  );

  // Codes leave four cycles after the pixel that completes their window
  riu2_encode u_riu2_encode (
    .clk             (clk),
    .rst_n           (rst_n),
    .ni_pattern_i    (ni_pattern),
    .rd_pattern_i    (rd_pattern),
    .pattern_valid_i (pattern_valid),
    .ni_code_o       (ni_o),
    .rd_code_o       (rd_o),
    .code_valid_o    (data_valid_o)
  );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic clk_o
);

  localparam real HALF_PERIOD = 2.0;  // 4 ns clock period

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

// ==== testbench/tb_nird.sv ====
`timescale 1ns/100ps

module tb_nird;
  import pixel_pkg::*;
  import code_pkg::*;

  localparam int ADDR_W       = 9;
  localparam int MEM_DEPTH    = 2 ** ADDR_W;
  localparam int RESET_CYCLES = 10;
  localparam int DRIVE_DELAY  = 1;  // Inputs change this many ns after the rising edge
  localparam int HEADER_WORDS = 4;  // Width, height, output count, idle cycles per pixel
  localparam int OUT_LATENCY  = 4;  // Cycles from the accepting edge to data_valid_o

  logic               clk;
  logic               rst_n;
  logic [COUNT_W-1:0] img_width;
  logic               sof;
  pixel_t             pixel;
  logic               pixel_valid;
  code_t              ni;
  code_t              rd;
  logic               data_valid;

  logic [15:0] tdata [MEM_DEPTH];
  logic [7:0]  expected_q [$];  // Upper nibble is NI, lower nibble RD
  int          due_q [$];       // Cycle at which each output beat must show up

  int total_pixels;
  int total_expected;
  int seen_count;
  int value_errors;
  int other_errors;
  int cycle_count;
  int cycle_limit;

  tb_clock u_clock (
    .clk_o (clk)
  );

  nird_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .img_width_i   (img_width),
    .sof_i         (sof),
    .pixel_i       (pixel),
    .pixel_valid_i (pixel_valid),
    .ni_o          (ni),
    .rd_o          (rd),
    .data_valid_o  (data_valid)
  );

  function automatic int read_word(input int addr);
    return int'(tdata[addr[ADDR_W-1:0]]);
  endfunction

  // Walks the frame records once to queue every expected code pair in order
  task automatic load_expected();
    int pos;
    int n_frames;
    int w;
    int h;
    int n_out;
    pos      = 1;
    n_frames = read_word(0);
    for (int f = 0; f < n_frames; f++) begin
      w     = read_word(pos);
      h     = read_word(pos + 1);
      n_out = read_word(pos + 2);
      // Only windows lying fully inside the image give a code pair
      if (n_out != (w - (WIN - 1)) * (h - (WIN - 1))) begin
        $display("Frame %0d lists %0d outputs but a %0dx%0d image gives %0d",
                 f, n_out, w, h, (w - (WIN - 1)) * (h - (WIN - 1)));
        other_errors++;
      end
      pos          = pos + HEADER_WORDS + w * h;
      total_pixels = total_pixels + w * h;
      for (int i = 0; i < n_out; i++) begin
        expected_q.push_back(8'(read_word(pos + i)));
      end
      pos = pos + n_out;
    end
    total_expected = expected_q.size();
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
  endtask

  task automatic drive_pixel(input pixel_t value, input logic first,
                             input logic [COUNT_W-1:0] width);
    @(posedge clk);
    #DRIVE_DELAY;
    pixel       = value;
    sof         = first;
    img_width   = width;
    pixel_valid = 1'b1;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #DRIVE_DELAY;
    sof         = 1'b0;
    pixel_valid = 1'b0;
  endtask

  // Frames follow each other directly, the next sof arrives right after the last pixel
  task automatic drive_frames();
    int pos;
    int n_frames;
    int w;
    int h;
    int n_out;
    int gap;
    pos      = 1;
    n_frames = read_word(0);
    for (int f = 0; f < n_frames; f++) begin
      w     = read_word(pos);
      h     = read_word(pos + 1);
      n_out = read_word(pos + 2);
      gap   = read_word(pos + 3);
      pos   = pos + HEADER_WORDS;
      for (int i = 0; i < w * h; i++) begin
        drive_pixel(pixel_t'(read_word(pos + i)), i == 0, COUNT_W'(w));
        // A pixel at column and row of at least 4 is the corner of a full window
        if ((i % w) >= WIN - 1 && (i / w) >= WIN - 1) begin
          due_q.push_back(cycle_count + 1 + OUT_LATENCY);  // Accepted at the next edge
        end
        repeat (gap) drive_idle();
      end
      pos = pos + w * h + n_out;
    end
    drive_idle();
  endtask

  task automatic check_beat();
    logic [7:0] pair;
    int         due;
    if (due_q.size() == 0) begin
      $display("Output beat %0d came without a completing pixel before it", seen_count);
      other_errors++;
    end else begin
      due = due_q.pop_front();
      if (due != cycle_count) begin
        $display("Output beat %0d came at cycle %0d where cycle %0d was due",
                 seen_count, cycle_count, due);
        other_errors++;
      end
    end
    if (expected_q.size() == 0) begin
      $display("Output beat %0d arrived after every expected code pair was used", seen_count);
      other_errors++;
    end else begin
      pair = expected_q.pop_front();
      if (ni !== pair[7:4]) begin
        $display("ERR ni_o beat %0d got %h expected %h", seen_count, ni, pair[7:4]);
        value_errors++;
      end
      if (rd !== pair[3:0]) begin
        $display("ERR rd_o beat %0d got %h expected %h", seen_count, rd, pair[3:0]);
        value_errors++;
      end
    end
    seen_count++;
  endtask

  task automatic report_counts();
    $display("Beats %0d of %0d, value errors %0d, other errors %0d",
             seen_count, total_expected, value_errors, other_errors);
  endtask

  // Outputs settle after the rising edge, so they are read half a period later
  always @(negedge clk) begin
    if (rst_n && data_valid) begin
      check_beat();
    end
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped at the %0d cycle limit with %0d expected outputs still unseen",
             cycle_limit, expected_q.size());
    other_errors++;
    report_counts();
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst_n          = 1'b0;
    sof            = 1'b0;
    pixel          = '0;
    pixel_valid    = 1'b0;
    img_width      = '0;
    total_pixels   = 0;
    total_expected = 0;
    seen_count     = 0;
    value_errors   = 0;
    other_errors   = 0;
    cycle_count    = 0;
    $readmemh("testbench/nird_testdata.hex", tdata);
    load_expected();
    if (total_expected == 0) begin
      $display("Test data file testbench/nird_testdata.hex gave no expected outputs");
      other_errors++;
    end
    cycle_limit = 2 * total_pixels + 100;
    apply_reset();
    drive_frames();
    while (seen_count < total_expected) begin
      @(negedge clk);
    end
    repeat (2 * WIN) @(negedge clk);  // A stray beat would show up within the pipeline depth
    if (seen_count != total_expected) begin
      $display("Saw %0d output beats where %0d were expected", seen_count, total_expected);
      other_errors++;
    end
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/nird_testdata.hex ====
// Word 0 is the frame count. Each frame: width height output_count idle_cycles_per_pixel,
// then the pixels in raster order, then one {NI, RD} code byte per window in raster order
4
// Flat 8x6 frame, every window fully set on both patterns
8 6 8 0
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
88 88 88 88 88 88 88 88
// Left to right ramp 6x5, one idle cycle after each pixel, east half and N/S set
6 5 2 1
10 30 50 70 90 b0
10 30 50 70 90 b0
10 30 50 70 90 b0
10 30 50 70 90 b0
10 30 50 70 90 b0
55 55
// Noise patch 5x5, outer ring alternates high and low so both patterns are non-uniform
5 5 1 0
20 80 c0 80 20
80 80 80 80 80
c0 80 80 80 c0
80 80 80 80 80
20 80 c0 80 20
99
// Bright pixel at the west edge of window 0 only, three idle cycles after each pixel
6 5 2 3
40 40 40 40 40 40
40 40 40 40 40 40
ff 40 40 40 40 40
40 40 40 40 40 40
40 40 40 40 40 40
18 88

// ==== sources.f ====
logic/pixel_pkg.sv
logic/code_pkg.sv
logic/ring_if.sv
logic/window_gen.sv
logic/ring_compare.sv
logic/riu2_encode.sv
logic/nird_top.sv
testbench/tb_clock.sv
testbench/tb_nird.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module tb_nird -f sources.f \
    -Mdir obj_dir -o sim_nird &&
  ./obj_dir/sim_nird | tee "$LOG" ||
  echo "Build or simulation did not complete"

grep -qx "TB PASSED" "$LOG" && echo "Simulation passed" || {
  echo "Simulation failed, see $LOG"
  exit 1
}

exit 0
